/* Bender.yml */
package:
  name: keystone

sources:
  - files:
      - source/keystone_pkg.sv
      - source/homography_if.sv
      - source/frame_read_if.sv
      - source/homography_regs.sv
      - source/frame_buffer.sv
      - source/coordinate_transform.sv
      - source/correction_sequencer.sv
      - source/keystone_top.sv

  - target: test
    files:
      - tests/keystone_tb.sv

/* build.f */
source/keystone_pkg.sv
source/homography_if.sv
source/frame_read_if.sv
source/homography_regs.sv
source/frame_buffer.sv
source/coordinate_transform.sv
source/correction_sequencer.sv
source/keystone_top.sv
tests/keystone_tb.sv

/* source/coordinate_transform.sv */
// Coordinate transform, stalling homography pipeline from destination pixel to fetched source pixel
`timescale 1ns/1ps

module coordinate_transform #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic advance,
    input  logic dest_valid,
    input  keystone_pkg::coord_t dest_x,
    input  keystone_pkg::coord_t dest_y,
    homography_if.transform coef,
    frame_read_if.requester rd,
    output logic result_valid,
    output keystone_pkg::rgb_t result_pixel
);

    localparam int PROD_BITS = 48;
    localparam int SUM_BITS = 50;

    // h33 in Q16.16
    localparam logic signed [SUM_BITS-1:0] ONE = 1 << keystone_pkg::FRAC_BITS;

    // num / den rounded half up, den is positive
    function automatic logic signed [SUM_BITS-1:0] round_div(
        input logic signed [SUM_BITS-1:0] num,
        input logic signed [SUM_BITS-1:0] den
    );
        logic signed [SUM_BITS+1:0] n2;
        logic signed [SUM_BITS+1:0] d2;
        n2 = num * 2 + den;
        d2 = den * 2;
        // Division truncates, bias negatives to get the floor
        if (n2 < 0) begin
            n2 = n2 - d2 + 1;
        end
        return SUM_BITS'(n2 / d2);
    endfunction

    keystone_pkg::coord_t cx;
    keystone_pkg::coord_t cy;
    logic signed [PROD_BITS-1:0] p_ax, p_by, p_dx;
    logic signed [PROD_BITS-1:0] p_ey, p_gx, p_hy;
    logic signed [SUM_BITS-1:0] xw, yw, w;
    logic signed [SUM_BITS-1:0] w_safe, qx, qy;
    logic q_in_range;
    keystone_pkg::coord_t s3_x;
    keystone_pkg::coord_t s3_y;
    logic s3_in_range;
    logic s4_in_range;
    logic s1_valid, s2_valid, s3_valid, s4_valid;

    //////////////////////////////////////////////////
    // Stage 1 products
    //////////////////////////////////////////////////

    assign cx = dest_x - keystone_pkg::coord_t'(WIDTH / 2);
    assign cy = dest_y - keystone_pkg::coord_t'(HEIGHT / 2);

    always_ff @(posedge clock) begin
        if (advance) begin
            p_ax <= coef.coeffs.a * cx;
            p_by <= coef.coeffs.b * cy;
            p_dx <= coef.coeffs.d * cx;
            p_ey <= coef.coeffs.e * cy;
            p_gx <= coef.coeffs.g * cx;
            p_hy <= coef.coeffs.h * cy;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2 sums
    //////////////////////////////////////////////////

    // Active set only changes between frames, c and f are read late
    always_ff @(posedge clock) begin
        if (advance) begin
            xw <= p_ax + p_by + coef.coeffs.c;
            yw <= p_dx + p_ey + coef.coeffs.f;
            w <= p_gx + p_hy + ONE;
        end
    end

    //////////////////////////////////////////////////
    // Stage 3 divide, round, restore
    //////////////////////////////////////////////////

    // Points behind the camera plane never divide
    assign w_safe = (w > 0) ? w : SUM_BITS'(1);
    assign qx = round_div(xw, w_safe) + WIDTH / 2;
    assign qy = round_div(yw, w_safe) + HEIGHT / 2;
    assign q_in_range = (w > 0) && (qx >= 0) && (qx < WIDTH) && (qy >= 0) && (qy < HEIGHT);

    always_ff @(posedge clock) begin
        if (advance) begin
            s3_x <= qx[15:0];
            s3_y <= qy[15:0];
            s3_in_range <= q_in_range;
            s4_in_range <= s3_in_range;
        end
    end

    // Stage 4 is the buffer read itself
    assign rd.request = advance && s3_valid && s3_in_range;
    assign rd.src_x = s3_x;
    assign rd.src_y = s3_y;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            s4_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= dest_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            s4_valid <= s3_valid;
        end
    end

    assign result_valid = s4_valid;
    assign result_pixel = s4_in_range ? rd.pixel : keystone_pkg::BLACK;

    result_valid_known: assert property (
        @(posedge clock) disable iff (reset) !$isunknown(result_valid)
    );

endmodule

/* source/correction_sequencer.sv */
// Correction sequencer, destination raster walk, pipeline stall control and framed output register
`timescale 1ns/1ps

module correction_sequencer #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic frame_full,
    output logic frame_release,
    homography_if.sequencer coef,
    output logic advance,
    output logic dest_valid,
    output keystone_pkg::coord_t dest_x,
    output keystone_pkg::coord_t dest_y,
    input  logic result_valid,
    input  keystone_pkg::rgb_t result_pixel,
    input  logic out_ready,
    output logic out_valid,
    output logic out_start_of_frame,
    output logic out_end_of_line,
    output keystone_pkg::rgb_t out_pixel
);

    localparam int PIXELS = WIDTH * HEIGHT;
    localparam int COUNT_BITS = $clog2(PIXELS + 1);
    localparam int COL_BITS = $clog2(WIDTH + 1);

    typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} state_t;

    state_t state;
    logic last_issue;
    logic out_fire;
    logic last_out;
    logic first_pending;
    logic [COL_BITS-1:0] mark_col;
    logic [COUNT_BITS-1:0] emit_count;

    // Whole pipeline moves unless the output is full and blocked
    assign advance = !out_valid || out_ready;
    assign out_fire = out_valid && out_ready;
    assign last_out = out_fire && (emit_count == COUNT_BITS'(PIXELS - 1));

    assign coef.load = (state == IDLE) && frame_full;
    assign dest_valid = (state == ISSUE);
    assign frame_release = (state == DRAIN) && last_out;

    assign last_issue = (dest_x == keystone_pkg::coord_t'(WIDTH - 1))
                     && (dest_y == keystone_pkg::coord_t'(HEIGHT - 1));

    //////////////////////////////////////////////////
    // Raster FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            dest_x <= '0;
            dest_y <= '0;
        end else begin
            case (state)
                IDLE: if (frame_full) state <= ISSUE;
                ISSUE: begin
                    if (advance) begin
                        if (last_issue) begin
                            state <= DRAIN;
                            dest_x <= '0;
                            dest_y <= '0;
                        end else if (dest_x == keystone_pkg::coord_t'(WIDTH - 1)) begin
                            dest_x <= '0;
                            dest_y <= dest_y + 1'b1;
                        end else begin
                            dest_x <= dest_x + 1'b1;
                        end
                    end
                end
                DRAIN: if (last_out) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Pixels that have left, for the release
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            emit_count <= '0;
        end else if (last_out) begin
            emit_count <= '0;
        end else if (out_fire) begin
            emit_count <= emit_count + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Output register and markers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_start_of_frame <= 1'b0;
            out_end_of_line <= 1'b0;
            first_pending <= 1'b1;
            mark_col <= '0;
        end else begin
            if (advance) begin
                out_valid <= result_valid;
                out_start_of_frame <= result_valid && first_pending;
                out_end_of_line <= result_valid && (mark_col == COL_BITS'(WIDTH - 1));
                if (result_valid) begin
                    first_pending <= 1'b0;
                    mark_col <= (mark_col == COL_BITS'(WIDTH - 1)) ? '0 : mark_col + 1'b1;
                end
            end
            // Pipeline is empty at the pulse
            if (coef.load) begin
                first_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            out_pixel <= result_pixel;
        end
    end

    out_stable_when_stalled: assert property (
        @(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> ($stable(out_pixel) && $stable(out_start_of_frame)
                                       && $stable(out_end_of_line))
    );

endmodule

/* source/frame_buffer.sv */
// Frame buffer storing one source frame from the input stream for coordinate lookups
`timescale 1ns/1ps

module frame_buffer #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic in_valid,
    input  logic in_start_of_frame,
    input  logic in_end_of_line,
    input  keystone_pkg::rgb_t in_pixel,
    output logic in_ready,
    output logic frame_full,
    input  logic frame_release,
    frame_read_if.store rd
);

    localparam int DEPTH = WIDTH * HEIGHT;
    localparam int ADDR_BITS = $clog2(DEPTH);
    localparam int COL_BITS = $clog2(WIDTH + 1);
    localparam int ROW_BITS = $clog2(HEIGHT + 1);

    keystone_pkg::rgb_t mem [DEPTH];

    logic [COL_BITS-1:0] wr_col;
    logic [COL_BITS-1:0] col_now;
    logic [ROW_BITS-1:0] wr_row;
    logic [ROW_BITS-1:0] row_now;
    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;
    logic accept;
    logic last_pos;

    // Closed from the last source pixel until the frame is released
    assign in_ready = !frame_full;
    assign accept = in_valid && in_ready;

    // Start of frame forces position 0,0
    assign col_now = in_start_of_frame ? '0 : wr_col;
    assign row_now = in_start_of_frame ? '0 : wr_row;

    assign last_pos = (col_now == COL_BITS'(WIDTH - 1)) && (row_now == ROW_BITS'(HEIGHT - 1));

    // Row major
    assign wr_addr = ADDR_BITS'(row_now * WIDTH + col_now);
    assign rd_addr = ADDR_BITS'(rd.src_y * WIDTH + rd.src_x);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_col <= '0;
            wr_row <= '0;
            frame_full <= 1'b0;
        end else if (frame_release) begin
            wr_col <= '0;
            wr_row <= '0;
            frame_full <= 1'b0;
        end else if (accept) begin
            if (in_end_of_line) begin
                wr_col <= '0;
                wr_row <= row_now + 1'b1;
            end else begin
                wr_col <= col_now + 1'b1;
                wr_row <= row_now;
            end
            if (last_pos) begin
                frame_full <= 1'b1;
            end
        end
    end

    // Storage and registered lookup, pixel holds between requests
    always_ff @(posedge clock) begin
        if (accept) begin
            mem[wr_addr] <= in_pixel;
        end
        if (rd.request) begin
            rd.pixel <= mem[rd_addr];
        end
    end

    // Once the frame is complete nothing more is written until release
    no_write_when_full: assert property (
        @(posedge clock) disable iff (reset)
        (accept && last_pos) |=> (!accept until frame_release)
    );

endmodule

/* source/frame_read_if.sv */
// Lookup read bus from the coordinate transform into the frame buffer
`timescale 1ns/1ps

interface frame_read_if;

    logic request;
    keystone_pkg::coord_t src_x;
    keystone_pkg::coord_t src_y;

    // Valid one clock after request, held otherwise
    keystone_pkg::rgb_t pixel;

    modport requester (
        output request, src_x, src_y,
        input  pixel
    );

    modport store (
        input  request, src_x, src_y,
        output pixel
    );

endinterface

/* source/homography_if.sv */
// Homography bus carrying the active coefficient set and the frame-start load pulse
`timescale 1ns/1ps

interface homography_if;

    // Active set used by the transform
    keystone_pkg::coeff_set_t coeffs;

    // One cycle pulse at the start of each corrected frame
    logic load;

    modport regs (
        input  load,
        output coeffs
    );

    modport sequencer (
        output load
    );

    modport transform (
        input coeffs
    );

endinterface

/* source/homography_regs.sv */
// Homography register block, Wishbone classic slave with shadow and active coefficients
`timescale 1ns/1ps

module homography_regs (
    input  logic clock,
    input  logic reset,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [keystone_pkg::REG_ADDR_BITS-1:0] wb_adr,
    input  keystone_pkg::coeff_t wb_dat_w,
    output keystone_pkg::coeff_t wb_dat_r,
    output logic wb_ack,
    homography_if.regs coef
);

    // Software view, index 0 is a
    keystone_pkg::coeff_t shadow [keystone_pkg::COEFF_COUNT];

    logic request;
    logic strobe;

    assign request = wb_cyc && wb_stb;

    // New request only, the acked cycle is the tail of the same one
    assign strobe = request && !wb_ack;

    //////////////////////////////////////////////////
    // Wishbone handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= strobe;
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clock) begin
        if (strobe) begin
            wb_dat_r <= shadow[wb_adr];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < keystone_pkg::COEFF_COUNT; i++) begin
                shadow[i] <= '0;
            end
        end else if (strobe && wb_we) begin
            shadow[wb_adr] <= wb_dat_w;
        end
    end

    //////////////////////////////////////////////////
    // Active set
    //////////////////////////////////////////////////

    // Copied once per frame so the next frame can be prepared meanwhile
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            coef.coeffs <= '0;
        end else if (coef.load) begin
            coef.coeffs <= {shadow[0], shadow[1], shadow[2], shadow[3],
                            shadow[4], shadow[5], shadow[6], shadow[7]};
        end
    end

    // Ack only ever answers a request seen the cycle before
    ack_follows_request: assert property (
        @(posedge clock) disable iff (reset) !request |=> !wb_ack
    );

endmodule

/* source/keystone_pkg.sv */
// Keystone package with the shared constants, fixed-point formats and pixel types
package keystone_pkg;

    // Coefficients are Q16.16
    localparam int FRAC_BITS = 16;

    // Eight homography registers, h33 is fixed at one
    localparam int COEFF_COUNT = 8;
    localparam int REG_ADDR_BITS = 3;

    typedef logic signed [31:0] coeff_t;

    // Centred or absolute pixel coordinate
    typedef logic signed [15:0] coord_t;

    // Red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // H11 H12 H13 H21 H22 H23 H31 H32
    typedef struct packed {
        coeff_t a;
        coeff_t b;
        coeff_t c;
        coeff_t d;
        coeff_t e;
        coeff_t f;
        coeff_t g;
        coeff_t h;
    } coeff_set_t;

    // Emitted when the lookup leaves the frame
    localparam rgb_t BLACK = '0;

endpackage

/* source/keystone_top.sv */
// Keystone correction engine top, joins registers, frame buffer, transform and sequencer
`timescale 1ns/1ps

module keystone_top #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 8
) (
    input  logic clock,
    input  logic reset,
    // Wishbone
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [keystone_pkg::REG_ADDR_BITS-1:0] wb_adr,
    input  keystone_pkg::coeff_t wb_dat_w,
    output keystone_pkg::coeff_t wb_dat_r,
    output logic wb_ack,
    // Source pixels
    input  logic in_valid,
    output logic in_ready,
    input  keystone_pkg::rgb_t in_pixel,
    input  logic in_start_of_frame,
    input  logic in_end_of_line,
    // Corrected pixels
    output logic out_valid,
    input  logic out_ready,
    output keystone_pkg::rgb_t out_pixel,
    output logic out_start_of_frame,
    output logic out_end_of_line
);

    logic frame_full;
    logic frame_release;
    logic advance;
    logic dest_valid;
    keystone_pkg::coord_t dest_x;
    keystone_pkg::coord_t dest_y;
    logic result_valid;
    keystone_pkg::rgb_t result_pixel;

    homography_if coef_bus ();
    frame_read_if rd_bus ();

    homography_regs u_regs (
        .clock(clock), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .coef(coef_bus.regs)
    );

    frame_buffer #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_buffer (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_start_of_frame(in_start_of_frame),
        .in_end_of_line(in_end_of_line), .in_pixel(in_pixel), .in_ready(in_ready),
        .frame_full(frame_full), .frame_release(frame_release), .rd(rd_bus.store)
    );

    coordinate_transform #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_transform (
        .clock(clock), .reset(reset), .advance(advance),
        .dest_valid(dest_valid), .dest_x(dest_x), .dest_y(dest_y),
        .coef(coef_bus.transform), .rd(rd_bus.requester),
        .result_valid(result_valid), .result_pixel(result_pixel)
    );

    correction_sequencer #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_sequencer (
        .clock(clock), .reset(reset),
        .frame_full(frame_full), .frame_release(frame_release), .coef(coef_bus.sequencer),
        .advance(advance), .dest_valid(dest_valid), .dest_x(dest_x), .dest_y(dest_y),
        .result_valid(result_valid), .result_pixel(result_pixel),
        .out_ready(out_ready), .out_valid(out_valid),
        .out_start_of_frame(out_start_of_frame), .out_end_of_line(out_end_of_line),
        .out_pixel(out_pixel)
    );

endmodule

/* tests/keystone_tb.sv */
// Keystone engine testbench with register access, three corrected frames and checking assertions
`timescale 1ns/1ps

module keystone_tb;

    localparam int WIDTH = 16;
    localparam int HEIGHT = 8;
    localparam int PIXELS = WIDTH * HEIGHT;
    localparam int FRAMES = 3;
    localparam int TOTAL = FRAMES * PIXELS;
    // Three frames of input and output at half rate plus Wishbone traffic and reset
    localparam int CYCLE_LIMIT = 6000;
    localparam int ONE = 65536;

    logic clock, reset;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [keystone_pkg::REG_ADDR_BITS-1:0] wb_adr;
    keystone_pkg::coeff_t wb_dat_w, wb_dat_r;
    logic in_valid, in_ready, in_start_of_frame, in_end_of_line;
    keystone_pkg::rgb_t in_pixel, out_pixel;
    logic out_valid, out_ready, out_start_of_frame, out_end_of_line;

    integer seed = 32'h76ce_ce6b;
    logic [31:0] rnd;
    logic random_ready = 1'b0;
    logic stall_phase;
    int errors = 0;
    int cycles = 0;
    int in_total = 0;
    int out_total = 0;

    // Reference copies of the source frames, the predicted output and the register file
    keystone_pkg::rgb_t src [FRAMES][PIXELS];
    keystone_pkg::rgb_t expected [TOTAL];
    int ref_regs [keystone_pkg::COEFF_COUNT];

    keystone_pkg::rgb_t expect_now;
    int reg_expect;
    logic sof_expect, eol_expect;

    assign expect_now = expected[out_total];
    assign reg_expect = ref_regs[wb_adr];
    assign sof_expect = (out_total % PIXELS == 0);
    assign eol_expect = (out_total % WIDTH == WIDTH - 1);

    keystone_top #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) DUT (
        .clock(clock), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .in_valid(in_valid), .in_ready(in_ready), .in_pixel(in_pixel),
        .in_start_of_frame(in_start_of_frame), .in_end_of_line(in_end_of_line),
        .out_valid(out_valid), .out_ready(out_ready), .out_pixel(out_pixel),
        .out_start_of_frame(out_start_of_frame), .out_end_of_line(out_end_of_line)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Accepted transfers on both streams
    always @(posedge clock) begin
        if (in_valid && in_ready) in_total <= in_total + 1;
        if (out_valid && out_ready) out_total <= out_total + 1;
    end

    // Sink readiness turns random once the stall phases begin
    initial begin
        forever begin
            @(posedge clock);
            stall_phase = random_ready;
            #5;
            if (stall_phase) begin
                rnd = $random(seed);
                out_ready = rnd[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    ack_one_cycle: assert property (@(posedge clock) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            errors++;
            $display("wb_ack did not rise one cycle after the request");
        end

    ack_single: assert property (@(posedge clock) disable iff (reset) wb_ack |=> !wb_ack)
        else begin
            errors++;
            $display("wb_ack stayed high for more than one cycle");
        end

    read_back: assert property (@(posedge clock) disable iff (reset)
        (wb_ack && !wb_we) |-> (wb_dat_r == reg_expect))
        else begin
            errors++;
            $display("[FAIL] wb_dat_r got %h expected %h", $sampled(wb_dat_r),
                     $sampled(reg_expect));
        end

    pixel_match: assert property (@(posedge clock) disable iff (reset)
        (out_valid && out_ready) |-> (out_pixel == expect_now))
        else begin
            errors++;
            $display("[FAIL] out_pixel got %h expected %h", $sampled(out_pixel),
                     $sampled(expect_now));
        end

    sof_match: assert property (@(posedge clock) disable iff (reset)
        (out_valid && out_ready) |-> (out_start_of_frame == sof_expect))
        else begin
            errors++;
            $display("[FAIL] out_start_of_frame got %h expected %h",
                     $sampled(out_start_of_frame), $sampled(sof_expect));
        end

    eol_match: assert property (@(posedge clock) disable iff (reset)
        (out_valid && out_ready) |-> (out_end_of_line == eol_expect))
        else begin
            errors++;
            $display("[FAIL] out_end_of_line got %h expected %h",
                     $sampled(out_end_of_line), $sampled(eol_expect));
        end

    // Output register frozen under back-pressure
    hold_on_stall: assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pixel)
            && $stable(out_start_of_frame) && $stable(out_end_of_line)))
        else begin
            errors++;
            $display("Output stream changed while stalled");
        end

    no_extra_pixels: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> (out_total < TOTAL))
        else begin
            errors++;
            $display("More corrected pixels than source pixels");
        end

    // Source side stays closed until the corrected frame has fully left
    held_until_drained: assert property (@(posedge clock) disable iff (reset)
        (in_total > out_total && in_total % PIXELS == 0) |-> !in_ready)
        else begin
            errors++;
            $display("Source input reopened before the frame had drained");
        end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Round to nearest with halves going up
    function automatic longint nearest_int(input longint num, input longint den);
        longint n;
        longint d;
        longint q;
        n = 2 * num + den;
        d = 2 * den;
        q = n / d;
        if (n < 0 && (n % d) != 0) q = q - 1;
        return q;
    endfunction

    // Expected output of frame k from the coefficients now in ref_regs
    task automatic predict_frame(input int k);
        longint cx, cy, xw, yw, w, sx, sy;
        for (int y = 0; y < HEIGHT; y++) begin
            for (int x = 0; x < WIDTH; x++) begin
                cx = x - WIDTH / 2;
                cy = y - HEIGHT / 2;
                xw = longint'(ref_regs[0]) * cx + longint'(ref_regs[1]) * cy + ref_regs[2];
                yw = longint'(ref_regs[3]) * cx + longint'(ref_regs[4]) * cy + ref_regs[5];
                w = longint'(ref_regs[6]) * cx + longint'(ref_regs[7]) * cy + ONE;
                expected[k * PIXELS + y * WIDTH + x] = keystone_pkg::BLACK;
                if (w > 0) begin
                    sx = nearest_int(xw, w) + WIDTH / 2;
                    sy = nearest_int(yw, w) + HEIGHT / 2;
                    if (sx >= 0 && sx < WIDTH && sy >= 0 && sy < HEIGHT)
                        expected[k * PIXELS + y * WIDTH + x] = src[k][sy * WIDTH + sx];
                end
            end
        end
    endtask

    // Wishbone request held through the acknowledged cycle and followed by one idle cycle
    task automatic access_register(input int idx, input logic write, input int value);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = write;
        wb_adr = 3'(idx);
        wb_dat_w = value;
        if (write) ref_regs[idx] = value;
        @(posedge clock);
        #5;
        while (!wb_ack) begin
            @(posedge clock);
            #5;
        end
        // Classic cycle ends at the edge where ack is seen
        @(posedge clock);
        #5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(posedge clock);
        #5;
    endtask

    task automatic load_coefficients(input int a, b, c, d, e, f, g, h);
        access_register(0, 1'b1, a);
        access_register(1, 1'b1, b);
        access_register(2, 1'b1, c);
        access_register(3, 1'b1, d);
        access_register(4, 1'b1, e);
        access_register(5, 1'b1, f);
        access_register(6, 1'b1, g);
        access_register(7, 1'b1, h);
    endtask

    // Stream one stored frame at one pixel per cycle while the buffer is open
    task automatic send_frame(input int k);
        for (int i = 0; i < PIXELS; i++) begin
            in_valid = 1'b1;
            in_pixel = src[k][i];
            in_start_of_frame = (i == 0);
            in_end_of_line = (i % WIDTH == WIDTH - 1);
            while (!in_ready) begin
                @(posedge clock);
                #5;
            end
            @(posedge clock);
            #5;
        end
        in_valid = 1'b0;
        in_start_of_frame = 1'b0;
        in_end_of_line = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        in_valid = 1'b0;
        in_pixel = '0;
        in_start_of_frame = 1'b0;
        in_end_of_line = 1'b0;
        out_ready = 1'b1;
        for (int r = 0; r < keystone_pkg::COEFF_COUNT; r++) ref_regs[r] = 0;
        for (int k = 0; k < FRAMES; k++) begin
            for (int i = 0; i < PIXELS; i++) begin
                rnd = $random(seed);
                src[k][i] = rnd[23:0];
            end
        end
        repeat (8) @(posedge clock);
        #5;
        reset = 1'b0;

        // Register write then read back
        for (int r = 0; r < keystone_pkg::COEFF_COUNT; r++) begin
            rnd = $random(seed);
            access_register(r, 1'b1, rnd);
        end
        for (int r = 0; r < keystone_pkg::COEFF_COUNT; r++) access_register(r, 1'b0, 0);

        // Identity
        load_coefficients(ONE, 0, 0, 0, ONE, 0, 0, 0);
        predict_frame(0);
        send_frame(0);

        // Shift right by three written while frame 0 is corrected
        load_coefficients(ONE, 0, 3 * ONE, 0, ONE, 0, 0, 0);
        predict_frame(1);
        random_ready = 1'b1;
        send_frame(1);

        // Shift with mild perspective for the last frame
        load_coefficients(ONE, 0, -2 * ONE, 0, ONE, ONE, 32'h1000, 0);
        predict_frame(2);
        send_frame(2);

        while (out_total < TOTAL) @(posedge clock);
        repeat (20) @(posedge clock);
        if (out_total != TOTAL) begin
            errors++;
            $display("Wrong number of corrected pixels, %0d instead of %0d", out_total, TOTAL);
        end
        $display("Errors: %0d, source pixels: %0d, corrected pixels: %0d",
                 errors, in_total, out_total);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Run limit
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles = cycles + 1;
        end
        $display("Timeout after %0d cycles with %0d corrected pixels", cycles, out_total);
        $display("Result: FAILED");
        $finish;
    end

endmodule
